/* card_glue_pkg.sv */
package card_glue_pkg;

    // Widths that carry a meaning
    typedef logic [7:0]         bus_byte_t;      // Apple data bus
    typedef logic [9:0]         audio_src_t;     // Unsigned source sample
    typedef logic [12:0]        audio_ext_t;     // Source widened for summing
    typedef logic signed [15:0] sample_t;        // Mixed output sample
    typedef logic [7:0]         color_t;
    typedef logic [9:0]         screen_coord_t;
    typedef logic [3:0]         dip_n_t;         // Switches, low when closed

    // One peripheral function as seen from the bus
    typedef struct packed {
        logic      rd;      // Function is answering this read
        bus_byte_t data;
        logic      irq_n;
    } card_resp_t;

    typedef struct packed {
        card_resp_t serial;
        card_resp_t sprite;
        card_resp_t sound;
    } card_resps_t;

    typedef struct packed {
        logic scanlines;
        logic speaker;
    } settings_t;

    typedef struct packed {
        logic       speaker;    // Single bit speaker toggle
        audio_src_t sprite;
        audio_src_t sound_l;
        audio_src_t sound_r;
    } audio_in_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    localparam int SPEAKER_SHIFT = 12;  // Speaker lands on the top bit of audio_ext_t
    localparam int SOURCE_SHIFT  = 3;
    localparam int DIP_SCANLINES = 0;
    localparam int DIP_SPEAKER   = 1;

endpackage

/* switch_settings.sv */
module switch_settings #(
    parameter bit SCANLINES_ENABLE = 1'b0,
    parameter bit SPEAKER_ENABLE   = 1'b0
) (
    input  logic                   clk_logic_w,
    input  logic                   rst_i,
    input  card_glue_pkg::dip_n_t  dip_n_i,
    output card_glue_pkg::settings_t settings_o
);

    localparam int DIP_W = $bits(card_glue_pkg::dip_n_t);

    // Switch lines are inverted on entry, so a cleared stage reads as all open
    logic [DIP_W-1:0] sw_meta_r;
    logic [DIP_W-1:0] sw_sync_r;

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            sw_meta_r <= '0;
            sw_sync_r <= '0;
        end else begin
            sw_meta_r <= ~dip_n_i;    // May go metastable
            sw_sync_r <= sw_meta_r;
        end
    end

    // Decode stage, build-time enables force a setting on
    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            settings_o.scanlines <= SCANLINES_ENABLE;
            settings_o.speaker   <= SPEAKER_ENABLE;
        end else begin
            settings_o.scanlines <= SCANLINES_ENABLE |
                                    sw_sync_r[card_glue_pkg::DIP_SCANLINES];
            settings_o.speaker   <= SPEAKER_ENABLE |
                                    sw_sync_r[card_glue_pkg::DIP_SPEAKER];
        end
    end

    // Downstream mixer and shader take these as clean levels
    a_settings_known: assert property (
        @(posedge clk_logic_w) disable iff (rst_i)
        !$isunknown(settings_o)
    ) else $error("settings_o went unknown");

endmodule

/* card_response_select.sv */
module card_response_select #(
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,
    parameter bit IRQ_OUT_ENABLE      = 1'b1
) (
    input  logic                       clk_logic_w,
    input  logic                       rst_i,
    input  card_glue_pkg::card_resps_t card_resps_i,
    input  card_glue_pkg::bus_byte_t   bus_data_i,
    output logic                       data_out_en_o,
    output card_glue_pkg::bus_byte_t   data_out_o,
    output logic                       irq_n_o
);

    logic                     rd_any_w;
    logic                     data_en_w;
    card_glue_pkg::bus_byte_t data_sel_w;
    logic                     irq_all_n_w;
    logic                     irq_n_w;

    assign rd_any_w = card_resps_i.serial.rd |
                      card_resps_i.sprite.rd |
                      card_resps_i.sound.rd;

    // Card only drives the bus when allowed at build time
    assign data_en_w = BUS_DATA_OUT_ENABLE & rd_any_w;

    // Serial wins, then sprite, then sound
    always_comb begin
        if (card_resps_i.serial.rd) begin
            data_sel_w = card_resps_i.serial.data;
        end else if (card_resps_i.sprite.rd) begin
            data_sel_w = card_resps_i.sprite.data;
        end else if (card_resps_i.sound.rd) begin
            data_sel_w = card_resps_i.sound.data;
        end else begin
            data_sel_w = bus_data_i;    // Nobody answers, keep bus value
        end
    end

    // Any function pulling low asserts the card interrupt
    assign irq_all_n_w = card_resps_i.serial.irq_n &
                         card_resps_i.sprite.irq_n &
                         card_resps_i.sound.irq_n;

    assign irq_n_w = irq_all_n_w | ~IRQ_OUT_ENABLE;

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            data_out_en_o <= 1'b0;
            irq_n_o       <= 1'b1;    // Released
        end else begin
            data_out_en_o <= data_en_w;
            irq_n_o       <= irq_n_w;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        data_out_o <= data_sel_w;
    end

    // Idle bus cycles must echo what the bus carried one cycle earlier
    a_idle_passthrough: assert property (
        @(posedge clk_logic_w) disable iff (rst_i)
        (BUS_DATA_OUT_ENABLE && !data_out_en_o) |-> (data_out_o == $past(bus_data_i))
    ) else $error("data_out_o differs from bus data while not driving");

endmodule

/* audio_mixer.sv */
module audio_mixer (
    input  logic                     clk_logic_w,
    input  logic                     rst_i,
    input  card_glue_pkg::audio_in_t audio_i,
    input  card_glue_pkg::settings_t settings_i,
    output card_glue_pkg::stereo_t   audio_o
);

    logic                      speaker_on_w;
    card_glue_pkg::audio_ext_t speaker_ext_w;
    card_glue_pkg::audio_ext_t sprite_ext_w;
    card_glue_pkg::audio_ext_t sound_l_ext_w;
    card_glue_pkg::audio_ext_t sound_r_ext_w;
    card_glue_pkg::sample_t    mix_l_w;
    card_glue_pkg::sample_t    mix_r_w;

    assign speaker_on_w = audio_i.speaker & settings_i.speaker;

    // Widen everything to 13 bits before summing
    assign speaker_ext_w = card_glue_pkg::audio_ext_t'(speaker_on_w)
                           << card_glue_pkg::SPEAKER_SHIFT;
    assign sprite_ext_w  = card_glue_pkg::audio_ext_t'(audio_i.sprite)
                           << card_glue_pkg::SOURCE_SHIFT;
    assign sound_l_ext_w = card_glue_pkg::audio_ext_t'(audio_i.sound_l)
                           << card_glue_pkg::SOURCE_SHIFT;
    assign sound_r_ext_w = card_glue_pkg::audio_ext_t'(audio_i.sound_r)
                           << card_glue_pkg::SOURCE_SHIFT;

    // Unsigned sources, so zero extended into the signed sample
    assign mix_l_w = card_glue_pkg::sample_t'({3'b000, sprite_ext_w}) +
                     card_glue_pkg::sample_t'({3'b000, sound_l_ext_w}) +
                     card_glue_pkg::sample_t'({3'b000, speaker_ext_w});

    assign mix_r_w = card_glue_pkg::sample_t'({3'b000, sprite_ext_w}) +
                     card_glue_pkg::sample_t'({3'b000, sound_r_ext_w}) +
                     card_glue_pkg::sample_t'({3'b000, speaker_ext_w});

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            audio_o <= '0;
        end else begin
            audio_o.left  <= mix_l_w;
            audio_o.right <= mix_r_w;
        end
    end

    // Largest sum is 2 * 8184 + 4096, well under the sign bit
    a_no_negative: assert property (
        @(posedge clk_logic_w) disable iff (rst_i)
        !audio_o.left[15] && !audio_o.right[15]
    ) else $error("mixed sample went negative");

endmodule

/* scanline_shader.sv */
module scanline_shader (
    input  logic                         clk_logic_w,
    input  logic                         rst_i,
    input  card_glue_pkg::rgb_t          pixel_i,
    input  card_glue_pkg::screen_coord_t screen_y_i,
    input  card_glue_pkg::settings_t     settings_i,
    output card_glue_pkg::rgb_t          pixel_o
);

    logic                dim_w;
    card_glue_pkg::rgb_t shaded_w;

    // Halve one channel, top bit cleared
    function automatic card_glue_pkg::color_t half_color(
        input card_glue_pkg::color_t c
    );
        return {1'b0, c[7:1]};
    endfunction

    assign dim_w = settings_i.scanlines & screen_y_i[0];    // Odd lines only

    always_comb begin
        if (dim_w) begin
            shaded_w.r = half_color(pixel_i.r);
            shaded_w.g = half_color(pixel_i.g);
            shaded_w.b = half_color(pixel_i.b);
        end else begin
            shaded_w = pixel_i;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            pixel_o <= '0;
        end else begin
            pixel_o <= shaded_w;
        end
    end

endmodule

/* card_glue_top.sv */
module card_glue_top #(
    parameter bit SCANLINES_ENABLE     = 1'b0,
    parameter bit APPLE_SPEAKER_ENABLE = 1'b0,
    parameter bit BUS_DATA_OUT_ENABLE  = 1'b1,  // Card may drive the data bus
    parameter bit IRQ_OUT_ENABLE       = 1'b1   // Card may pull IRQ
) (
    input  logic                         clk_logic_w,
    input  logic                         rst_i,

    input  card_glue_pkg::dip_n_t        dip_n_i,

    input  card_glue_pkg::card_resps_t   card_resps_i,
    input  card_glue_pkg::bus_byte_t     bus_data_i,
    output logic                         data_out_en_o,
    output card_glue_pkg::bus_byte_t     data_out_o,
    output logic                         irq_n_o,

    input  card_glue_pkg::audio_in_t     audio_i,
    output card_glue_pkg::stereo_t       audio_o,

    input  card_glue_pkg::rgb_t          pixel_i,
    input  card_glue_pkg::screen_coord_t screen_y_i,
    output card_glue_pkg::rgb_t          pixel_o,

    output card_glue_pkg::settings_t     settings_o
);

    card_glue_pkg::settings_t settings_w;

    assign settings_o = settings_w;

    switch_settings #(
        .SCANLINES_ENABLE (SCANLINES_ENABLE),
        .SPEAKER_ENABLE   (APPLE_SPEAKER_ENABLE)
    ) switch_settings_i (
        .clk_logic_w (clk_logic_w),
        .rst_i       (rst_i),
        .dip_n_i     (dip_n_i),
        .settings_o  (settings_w)
    );

    card_response_select #(
        .BUS_DATA_OUT_ENABLE (BUS_DATA_OUT_ENABLE),
        .IRQ_OUT_ENABLE      (IRQ_OUT_ENABLE)
    ) card_response_select_i (
        .clk_logic_w   (clk_logic_w),
        .rst_i         (rst_i),
        .card_resps_i  (card_resps_i),
        .bus_data_i    (bus_data_i),
        .data_out_en_o (data_out_en_o),
        .data_out_o    (data_out_o),
        .irq_n_o       (irq_n_o)
    );

    audio_mixer audio_mixer_i (
        .clk_logic_w (clk_logic_w),
        .rst_i       (rst_i),
        .audio_i     (audio_i),
        .settings_i  (settings_w),
        .audio_o     (audio_o)
    );

    scanline_shader scanline_shader_i (
        .clk_logic_w (clk_logic_w),
        .rst_i       (rst_i),
        .pixel_i     (pixel_i),
        .screen_y_i  (screen_y_i),
        .settings_i  (settings_w),
        .pixel_o     (pixel_o)
    );

endmodule

/* tb_card_glue.sv */
module tb_card_glue;

    localparam int N_DIRECTED     = 8;
    localparam int N_RANDOM       = 24;
    localparam int NUM_ROWS       = N_DIRECTED + N_RANDOM;
    localparam int HOLD_CYCLES    = 5;     // Covers the 4 cycle switch-to-output path
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS * HOLD_CYCLES + 50;

    // One stimulus row with its expected responses
    typedef struct packed {
        card_glue_pkg::dip_n_t        dip_n;
        card_glue_pkg::card_resps_t   resps;
        card_glue_pkg::bus_byte_t     bus;
        card_glue_pkg::audio_in_t     audio;
        card_glue_pkg::rgb_t          pixel;
        card_glue_pkg::screen_coord_t y;
        card_glue_pkg::settings_t     exp_set;
        logic                         exp_en;
        card_glue_pkg::bus_byte_t     exp_byte;
        logic                         exp_irq_n;
        card_glue_pkg::stereo_t       exp_audio;
        card_glue_pkg::rgb_t          exp_pixel;
    } row_t;

    logic                         clk_logic_w;
    logic                         rst;
    card_glue_pkg::dip_n_t        dip_n;
    card_glue_pkg::card_resps_t   card_resps;
    card_glue_pkg::bus_byte_t     bus_data;
    logic                         data_out_en;
    card_glue_pkg::bus_byte_t     data_out;
    logic                         irq_n;
    card_glue_pkg::audio_in_t     audio_in;
    card_glue_pkg::stereo_t       audio_out;
    card_glue_pkg::rgb_t          pixel_in;
    card_glue_pkg::screen_coord_t screen_y;
    card_glue_pkg::rgb_t          pixel_out;
    card_glue_pkg::settings_t     settings;

    row_t        rows [NUM_ROWS];
    int          n_rows;
    int          cycle_count;
    logic [31:0] lfsr_q;

    card_glue_top card_glue_top_i (
        .clk_logic_w   (clk_logic_w),
        .rst_i         (rst),
        .dip_n_i       (dip_n),
        .card_resps_i  (card_resps),
        .bus_data_i    (bus_data),
        .data_out_en_o (data_out_en),
        .data_out_o    (data_out),
        .irq_n_o       (irq_n),
        .audio_i       (audio_in),
        .audio_o       (audio_out),
        .pixel_i       (pixel_in),
        .screen_y_i    (screen_y),
        .pixel_o       (pixel_out),
        .settings_o    (settings)
    );

    always #5 clk_logic_w = ~clk_logic_w;

    task automatic fail_stop(input string why);
        $display("Some tests failed");
        $fatal(1, "%s", why);
    endtask

    always @(posedge clk_logic_w) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycle_count);
            fail_stop("cycle limit reached");
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};    // One step per bit
        end
    endtask

    // Closed switch reads low, build-time enables are off
    function automatic card_glue_pkg::settings_t ref_settings(input card_glue_pkg::dip_n_t d);
        card_glue_pkg::settings_t s;
        s.scanlines = ~d[0];
        s.speaker   = ~d[1];
        return s;
    endfunction

    function automatic card_glue_pkg::bus_byte_t ref_data(
        input card_glue_pkg::card_resps_t r,
        input card_glue_pkg::bus_byte_t bus
    );
        casez ({r.serial.rd, r.sprite.rd, r.sound.rd})
            3'b1??:  return r.serial.data;
            3'b01?:  return r.sprite.data;
            3'b001:  return r.sound.data;
            default: return bus;
        endcase
    endfunction

    // Sources scaled by 8, speaker worth 4096
    function automatic card_glue_pkg::sample_t ref_mix(
        input card_glue_pkg::audio_src_t a,
        input card_glue_pkg::audio_src_t b,
        input logic spk_on
    );
        int sum;
        sum = int'(a) * 8 + int'(b) * 8 + (spk_on ? 4096 : 0);
        return card_glue_pkg::sample_t'(sum);
    endfunction

    function automatic card_glue_pkg::rgb_t ref_pixel(
        input card_glue_pkg::rgb_t p,
        input card_glue_pkg::screen_coord_t y,
        input logic scan_on
    );
        card_glue_pkg::rgb_t q;
        q = p;
        if (scan_on && y[0]) begin
            q.r = p.r / 8'd2;
            q.g = p.g / 8'd2;
            q.b = p.b / 8'd2;
        end
        return q;
    endfunction

    task automatic add_row(
        input card_glue_pkg::dip_n_t d,
        input card_glue_pkg::card_resps_t r,
        input card_glue_pkg::bus_byte_t bus,
        input card_glue_pkg::audio_in_t a,
        input card_glue_pkg::rgb_t p,
        input card_glue_pkg::screen_coord_t y
    );
        row_t row;
        card_glue_pkg::settings_t s;
        s = ref_settings(d);
        row.dip_n           = d;
        row.resps           = r;
        row.bus             = bus;
        row.audio           = a;
        row.pixel           = p;
        row.y               = y;
        row.exp_set         = s;
        row.exp_en          = r.serial.rd | r.sprite.rd | r.sound.rd;
        row.exp_byte        = ref_data(r, bus);
        row.exp_irq_n       = r.serial.irq_n & r.sprite.irq_n & r.sound.irq_n;
        row.exp_audio.left  = ref_mix(a.sprite, a.sound_l, a.speaker & s.speaker);
        row.exp_audio.right = ref_mix(a.sprite, a.sound_r, a.speaker & s.speaker);
        row.exp_pixel       = ref_pixel(p, y, s.scanlines);
        rows[n_rows] = row;
        n_rows++;
    endtask

    task automatic check_byte(input string name, input card_glue_pkg::bus_byte_t got,
                              input card_glue_pkg::bus_byte_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
            fail_stop("byte mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
            fail_stop("bit mismatch");
        end
    endtask

    task automatic check_sample(input string name, input card_glue_pkg::sample_t got,
                                input card_glue_pkg::sample_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            fail_stop("sample mismatch");
        end
    endtask

    task automatic check_rgb(input string name, input card_glue_pkg::rgb_t got,
                             input card_glue_pkg::rgb_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
            fail_stop("pixel mismatch");
        end
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clk_logic_w);
        dip_n      <= r.dip_n;
        card_resps <= r.resps;
        bus_data   <= r.bus;
        audio_in   <= r.audio;
        pixel_in   <= r.pixel;
        screen_y   <= r.y;
        repeat (HOLD_CYCLES - 1) @(posedge clk_logic_w);
        @(negedge clk_logic_w);    // Outputs settled mid-cycle
        check_bit("settings_o.scanlines", settings.scanlines, r.exp_set.scanlines);
        check_bit("settings_o.speaker", settings.speaker, r.exp_set.speaker);
        check_bit("data_out_en_o", data_out_en, r.exp_en);
        check_byte("data_out_o", data_out, r.exp_byte);
        check_bit("irq_n_o", irq_n, r.exp_irq_n);
        check_sample("audio_o.left", audio_out.left, r.exp_audio.left);
        check_sample("audio_o.right", audio_out.right, r.exp_audio.right);
        check_rgb("pixel_o", pixel_out, r.exp_pixel);
    endtask

    initial begin
        logic [31:0]                bits;
        logic [2:0]                 irq_pat;
        card_glue_pkg::card_resps_t resps;
        card_glue_pkg::audio_in_t   aud;
        card_glue_pkg::rgb_t        pix;
        clk_logic_w = 1'b0;
        rst         = 1'b1;
        dip_n       = 4'hF;          // All switches open
        card_resps  = '0;
        bus_data    = '0;
        audio_in    = '0;
        pixel_in    = '0;
        screen_y    = '0;
        cycle_count = 0;
        n_rows      = 0;
        lfsr_q      = 32'h22a50bf2;

        // Every strobe and interrupt combination, all four switch settings
        for (int i = 0; i < N_DIRECTED; i++) begin
            irq_pat = 3'(i * 5);
            resps.serial = '{rd: i[2], data: 8'hA1, irq_n: irq_pat[2]};
            resps.sprite = '{rd: i[1], data: 8'hB2, irq_n: irq_pat[1]};
            resps.sound  = '{rd: i[0], data: 8'hC3, irq_n: irq_pat[0]};
            aud = '{speaker: 1'b1, sprite: 10'h3FF, sound_l: 10'h3FF, sound_r: 10'h155};
            pix = '{r: 8'hFF - 8'(i), g: 8'h80, b: 8'h01 + 8'(i)};
            add_row({2'b10, i[2], i[1]}, resps, 8'h5C + 8'(i), aud, pix, 10'(i));
        end

        for (int k = 0; k < N_RANDOM; k++) begin
            take_bits(4, bits);
            rows[n_rows].dip_n = bits[3:0];    // Kept until add_row below
            take_bits(30, bits);
            resps = bits[29:0];
            take_bits(31, bits);
            aud = bits[30:0];
            take_bits(24, bits);
            pix = bits[23:0];
            take_bits(18, bits);
            add_row(rows[n_rows].dip_n, resps, bits[17:10], aud, pix, bits[9:0]);
        end

        repeat (RESET_CYCLES) @(posedge clk_logic_w);
        rst <= 1'b0;
        @(negedge clk_logic_w);
        check_bit("data_out_en_o", data_out_en, 1'b0);
        check_bit("irq_n_o", irq_n, 1'b1);
        check_sample("audio_o.left", audio_out.left, 16'sd0);
        check_sample("audio_o.right", audio_out.right, 16'sd0);
        check_bit("settings_o.scanlines", settings.scanlines, 1'b0);
        check_bit("settings_o.speaker", settings.speaker, 1'b0);
        check_rgb("pixel_o", pixel_out, 24'h000000);

        for (int n = 0; n < n_rows; n++) begin
            apply_row(rows[n]);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

/* sources.f */
card_glue_pkg.sv
switch_settings.sv
card_response_select.sv
audio_mixer.sv
scanline_shader.sv
card_glue_top.sv
tb_card_glue.sv

/* Makefile */
# Verilator build and run of the card glue testbench

TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_card_glue
FILELIST = sources.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

# The run exits non-zero on any failure, so make fails with it
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
